/* all.f */
+incdir+logic
+incdir+verif
logic/bucketPkg.sv
logic/cipherPkg.sv
logic/chunkFifo.sv
logic/bucketTracker.sv
logic/keystreamGen.sv
logic/pathCipherCtrl.sv
logic/bucketCipher.sv
verif/bucketCipherTb.sv

/* Makefile */
# Verilator build and run for the bucket cipher testbench

VERILATOR ?= verilator
TOP       ?= bucketCipherTb
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --timing --assert --timescale 1ns/1ns
PASS_TEXT ?= TEST RESULT: PASS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^$(PASS_TEXT)$$"

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR)

/* verif/cipherModel.svh */
//----------------------------------------------------------------------
// Reference keystream and chunk transform for a module that imports
// bucketPkg and cipherPkg. Positions are 0 to BktChunks-1.
//----------------------------------------------------------------------
`ifndef CIPHER_MODEL_SVH
`define CIPHER_MODEL_SVH

// Counter is IV plus position, then Rounds keyed mixing steps
function automatic ctrBlockT refKeystream(input ivT iv, input int pos);
    ctrBlockT blk;
    ctrBlockT keyed;
    int       r;
    blk = {{(`ChunkBits-`IvBits){1'b0}}, iv} + 128'(pos);
    for (r = 0; r < `Rounds; r++) begin
        keyed = blk ^ `CipherKey;
        // Rotate left by 13
        blk = (keyed << 13) | (keyed >> (`ChunkBits - 13));
        blk = blk + `RoundConst * 128'(r + 1);
    end
    return blk;
endfunction

// One chunk in and one chunk out with the IV slice passed in clear
function automatic chunkT refChunk(input int pos, input ivT iv, input chunkT chunk);
    chunkT res;
    res = chunk ^ refKeystream(iv, pos);
    if (pos == `IvIndex) begin
        res[`IvBits-1:0] = chunk[`IvBits-1:0];
    end
    return res;
endfunction

`endif

/* verif/bucketCipherTb.sv */
//----------------------------------------------------------------------
// Runs three paths of PathBuckets buckets in turn. The read-back path
// replays captured ciphertext and later paths see random output stalls.
//----------------------------------------------------------------------
`timescale 1ns/1ns
`include "oram_macros.svh"

module bucketCipherTb import bucketPkg::*; import cipherPkg::*; ();

    localparam int Period     = 8;
    localparam int PathChunks = `BktChunks * `PathBuckets;
    localparam int NumPaths   = 3;

    `include "cipherModel.svh"

    logic  Clock;
    logic  arstN;
    chunkT backendWData;
    logic  backendWValid;
    logic  backendWReady;
    chunkT dramRData;
    logic  dramRValid;
    logic  dramRReady;
    chunkT dramWData;
    logic  dramWValid;
    logic  dramWReady;
    chunkT backendRData;
    logic  backendRValid;
    logic  backendRReady;

    chunkT expDramQ[$];
    chunkT expBackQ[$];
    chunkT cipherQ[$];
    ivT    ivQ[$];
    chunkT stim[PathChunks];
    chunkT plain[PathChunks];
    int    outCount = 0;
    int    checkCount = 0;
    int    errCount = 0;
    bit    randReady = 1'b0;

    bucketCipher UUT (.*);

    initial begin
        Clock = 1'b0;
        forever #(Period/2) Clock = ~Clock;
    end

    // Output back-pressure changes on the falling edge
    always @(negedge Clock) begin
        dramWReady    = !randReady || (($urandom % 4) != 0);
        backendRReady = !randReady || (($urandom % 4) != 0);
    end

    //------------------------------------------------------------------
    // Compare process
    //------------------------------------------------------------------

    task automatic checkOut(input bit toDram, input chunkT act);
        chunkT exp;
        string portName;
        if (toDram) portName = "dramWData";
        else portName = "backendRData";
        if ((toDram && expDramQ.size() == 0) || (!toDram && expBackQ.size() == 0)) begin
            $display("Unexpected chunk on %s at %0t", portName, $time);
            errCount++;
        end else begin
            if (toDram) exp = expDramQ.pop_front();
            else exp = expBackQ.pop_front();
            checkCount++;
            assert (act == exp) else begin
                $display("error: time %0t %s expected %h actual %h",
                         $time, portName, exp, act);
                errCount++;
            end
            // Clear IV in the IV chunk of every bucket
            if (outCount % `BktChunks == `IvIndex) begin
                exp[`IvBits-1:0] = ivQ.pop_front();
                checkCount++;
                assert (act[`IvBits-1:0] == exp[`IvBits-1:0]) else begin
                    $display("error: time %0t %s IV expected %h actual %h",
                             $time, portName, exp[`IvBits-1:0], act[`IvBits-1:0]);
                    errCount++;
                end
            end
            if (toDram) cipherQ.push_back(act);
            outCount++;
        end
    endtask

    always @(posedge Clock) begin
        if (arstN) begin
            assert (!(dramWValid && backendRValid)) else begin
                $display("Both output ports valid at %0t", $time);
                errCount++;
            end
            if (dramWValid && dramWReady) checkOut(1'b1, dramWData);
            if (backendRValid && backendRReady) checkOut(1'b0, backendRData);
        end
    end

    //------------------------------------------------------------------
    // Stimulus
    //------------------------------------------------------------------

    // Valid holds until ready is seen before the rising edge
    task automatic sendChunk(input bit viaDram, input chunkT data);
        @(negedge Clock);
        if (viaDram) begin
            dramRData  = data;
            dramRValid = 1'b1;
        end else begin
            backendWData  = data;
            backendWValid = 1'b1;
        end
        #1;
        while (!(viaDram ? dramRReady : backendWReady)) begin
            @(negedge Clock);
            #1;
        end
        @(posedge Clock);
    endtask

    task automatic sendPath(input bit viaDram, input bit gaps);
        for (int i = 0; i < PathChunks; i++) begin
            if (gaps && ($urandom % 3) == 0) begin
                @(negedge Clock);
                backendWValid = 1'b0;
                dramRValid    = 1'b0;
            end
            sendChunk(viaDram, stim[i]);
        end
        @(negedge Clock);
        backendWValid = 1'b0;
        dramRValid    = 1'b0;
    endtask

    task automatic randomStim();
        for (int i = 0; i < PathChunks; i++) begin
            stim[i] = {$urandom, $urandom, $urandom, $urandom};
        end
    endtask

    // Expected DRAM output for the plaintext now in stim
    task automatic expectEncrypt();
        ivT iv;
        for (int i = 0; i < PathChunks; i++) begin
            iv = stim[(i / `BktChunks) * `BktChunks + `IvIndex][`IvBits-1:0];
            if (i % `BktChunks == 0) ivQ.push_back(iv);
            expDramQ.push_back(refChunk(i % `BktChunks, iv, stim[i]));
        end
    endtask

    task automatic waitDrain(input string name, input int errMark);
        while (expDramQ.size() != 0 || expBackQ.size() != 0) @(posedge Clock);
        $display("%s finished with %0d errors", name, errCount - errMark);
    endtask

    initial begin
        int errMark;
        void'($urandom(32'h6b96c24c));
        arstN         = 1'b0;
        backendWData  = '0;
        backendWValid = 1'b0;
        dramRData     = '0;
        dramRValid    = 1'b0;
        dramWReady    = 1'b1;
        backendRReady = 1'b1;
        repeat (8) @(posedge Clock);
        @(negedge Clock);
        arstN = 1'b1;

        // Idle outputs after reset
        errMark = errCount;
        repeat (4) @(negedge Clock);
        checkCount++;
        assert (!dramWValid && !backendRValid) else begin
            $display("Output valid raised with no input after reset");
            errCount++;
        end
        $display("Reset state finished with %0d errors", errCount - errMark);

        // First path goes from backend write to DRAM
        errMark = errCount;
        randomStim();
        plain = stim;
        expectEncrypt();
        sendPath(1'b0, 1'b0);
        waitDrain("Write path", errMark);

        // Captured ciphertext returns through DRAM read under back-pressure
        errMark = errCount;
        randReady = 1'b1;
        for (int i = 0; i < PathChunks; i++) begin
            stim[i] = cipherQ[i];
            expBackQ.push_back(plain[i]);
            if (i % `BktChunks == `IvIndex) ivQ.push_back(plain[i][`IvBits-1:0]);
        end
        sendPath(1'b1, 1'b0);
        waitDrain("Read-back path", errMark);

        // Third path returns to DRAM write under back-pressure
        errMark = errCount;
        randomStim();
        expectEncrypt();
        sendPath(1'b0, 1'b1);
        waitDrain("Back-pressure path", errMark);
        randReady = 1'b0;

        repeat (10) @(posedge Clock);
        $display("Checks %0d, errors %0d", checkCount, errCount);
        if (errCount == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

    // Ends the run after 200 cycles per chunk plus margin
    initial begin
        #((200 * NumPaths * PathChunks + 1000) * Period);
        $display("Watchdog expired before all chunks came out");
        $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

/* logic/bucketCipher.sv */
//----------------------------------------------------------------------
// Bucket-level counter-mode cipher between ORAM backend and DRAM.
// Every path is PathBuckets buckets; IV sits in chunk IvIndex.
//----------------------------------------------------------------------
`timescale 1ns/1ns

module bucketCipher import bucketPkg::*; import cipherPkg::*; (
    input  logic  Clock,
    input  logic  arstN,

    // Backend write path in
    input  chunkT backendWData,
    input  logic  backendWValid,
    output logic  backendWReady,

    // DRAM read path in
    input  chunkT dramRData,
    input  logic  dramRValid,
    output logic  dramRReady,

    // DRAM write path out
    output chunkT dramWData,
    output logic  dramWValid,
    input  logic  dramWReady,

    // Backend read path out
    output chunkT backendRData,
    output logic  backendRValid,
    input  logic  backendRReady
);

    //------------------------------------------------------------------
    // Internal links
    //------------------------------------------------------------------

    chunkT    dataPushData;
    logic     dataPushValid;
    logic     dataPushReady;
    chunkT    dataHead;
    logic     dataHeadValid;
    logic     dataHeadReady;

    ivT       ivPushData;
    logic     ivPushValid;
    logic     ivPushReady;
    ivT       ivHead;
    logic     ivHeadValid;
    logic     ivHeadReady;

    ctrBlockT ksPushData;
    logic     ksPushValid;
    logic     ksPushReady;
    ctrBlockT ksHead;
    logic     ksHeadValid;
    logic     ksHeadReady;

    //------------------------------------------------------------------
    // Input side
    //------------------------------------------------------------------

    bucketTracker tracker (
        .Clock, .arstN,
        .backendWData, .backendWValid, .backendWReady,
        .dramRData, .dramRValid, .dramRReady,
        .dataOut(dataPushData), .dataValid(dataPushValid), .dataReady(dataPushReady),
        .ivOut(ivPushData), .ivValid(ivPushValid), .ivReady(ivPushReady)
    );

    chunkFifo #(.payloadT(chunkT)) dataFifo (
        .Clock, .arstN,
        .inData(dataPushData), .inValid(dataPushValid), .inReady(dataPushReady),
        .outData(dataHead), .outValid(dataHeadValid), .outReady(dataHeadReady)
    );

    chunkFifo #(.payloadT(ivT)) ivFifo (
        .Clock, .arstN,
        .inData(ivPushData), .inValid(ivPushValid), .inReady(ivPushReady),
        .outData(ivHead), .outValid(ivHeadValid), .outReady(ivHeadReady)
    );

    //------------------------------------------------------------------
    // Keystream side
    //------------------------------------------------------------------

    keystreamGen ksGen (
        .Clock, .arstN,
        .ivIn(ivHead), .ivValid(ivHeadValid), .ivReady(ivHeadReady),
        .ksOut(ksPushData), .ksValid(ksPushValid), .ksReady(ksPushReady)
    );

    chunkFifo #(.payloadT(ctrBlockT)) ksFifo (
        .Clock, .arstN,
        .inData(ksPushData), .inValid(ksPushValid), .inReady(ksPushReady),
        .outData(ksHead), .outValid(ksHeadValid), .outReady(ksHeadReady)
    );

    //------------------------------------------------------------------
    // Output side
    //------------------------------------------------------------------

    pathCipherCtrl outCtrl (
        .Clock, .arstN,
        .dataIn(dataHead), .dataValid(dataHeadValid), .dataReady(dataHeadReady),
        .ksIn(ksHead), .ksValid(ksHeadValid), .ksReady(ksHeadReady),
        .dramWData, .dramWValid, .dramWReady,
        .backendRData, .backendRValid, .backendRReady
    );

endmodule

/* logic/pathCipherCtrl.sv */
//----------------------------------------------------------------------
// Joins data and keystream, restores the clear IV, and steers each
// path to DRAM or backend. Direction starts at PathWrite.
//----------------------------------------------------------------------
`timescale 1ns/1ns
`include "oram_macros.svh"

module pathCipherCtrl import bucketPkg::*; import cipherPkg::*; (
    input  logic     Clock,
    input  logic     arstN,
    input  chunkT    dataIn,
    input  logic     dataValid,
    output logic     dataReady,
    input  ctrBlockT ksIn,
    input  logic     ksValid,
    output logic     ksReady,
    output chunkT    dramWData,
    output logic     dramWValid,
    input  logic     dramWReady,
    output chunkT    backendRData,
    output logic     backendRValid,
    input  logic     backendRReady
);

    pathDirT  dir;
    pathIdxT  pathPos;
    chunkIdxT outPos;
    logic     outValid;
    logic     outReady;
    logic     xfer;
    chunkT    xorRes;
    chunkT    outChunk;

    //------------------------------------------------------------------
    // Join and XOR
    //------------------------------------------------------------------

    assign outReady = (dir == PathWrite) ? dramWReady : backendRReady;
    assign outValid = dataValid & ksValid;
    assign xfer     = outValid & outReady;

    // Pop both FIFOs together
    assign dataReady = ksValid & outReady;
    assign ksReady   = dataValid & outReady;

    // Buckets tile the path, so the low bits give the bucket slot
    assign outPos = chunkIdxT'(pathPos % `BktChunks);
    assign xorRes = dataIn ^ chunkT'(ksIn);

    always_comb begin
        outChunk = xorRes;
        // IV travels in clear
        if (outPos == chunkIdxT'(`IvIndex)) outChunk[`IvBits-1:0] = dataIn[`IvBits-1:0];
    end

    //------------------------------------------------------------------
    // Steering
    //------------------------------------------------------------------

    assign dramWData     = outChunk;
    assign backendRData  = outChunk;
    assign dramWValid    = outValid & (dir == PathWrite);
    assign backendRValid = outValid & (dir == PathRead);

    // Flip direction after the last chunk of a path
    always_ff @(posedge Clock or negedge arstN) begin
        if (!arstN) begin
            pathPos <= '0;
            dir     <= PathWrite;
        end else if (xfer) begin
            if (pathPos == pathIdxT'(`BktChunks * `PathBuckets - 1)) begin
                pathPos <= '0;
                dir     <= (dir == PathWrite) ? PathRead : PathWrite;
            end else begin
                pathPos <= pathPos + 1'b1;
            end
        end
    end

endmodule

/* logic/keystreamGen.sv */
//----------------------------------------------------------------------
// Counter-mode keystream with one block per chunk of a bucket. Fixed
// latency of Rounds cycles. The whole pipe stalls when ksReady is low.
//----------------------------------------------------------------------
`timescale 1ns/1ns
`include "oram_macros.svh"

module keystreamGen import bucketPkg::*; import cipherPkg::*; (
    input  logic     Clock,
    input  logic     arstN,
    input  ivT       ivIn,
    input  logic     ivValid,
    output logic     ivReady,
    output ctrBlockT ksOut,
    output logic     ksValid,
    input  logic     ksReady
);

    localparam int RotBits = 13;

    chunkIdxT issuePos;
    logic     advance;
    logic     issue;
    ctrBlockT ctrValue;
    ctrBlockT stageData [`Rounds];
    logic     stageVld [`Rounds];

    // Key XOR and rotate left, then add the scaled round constant
    function automatic ctrBlockT mixRound(input ctrBlockT blk, input roundIdxT rnd);
        ctrBlockT keyed;
        ctrBlockT rotated;
        ctrBlockT scale;
        keyed   = blk ^ `CipherKey;
        rotated = {keyed[`ChunkBits-RotBits-1:0], keyed[`ChunkBits-1:`ChunkBits-RotBits]};
        scale   = ctrBlockT'(rnd) + ctrBlockT'(1);
        return rotated + `RoundConst * scale;
    endfunction

    //------------------------------------------------------------------
    // Counter issue
    //------------------------------------------------------------------

    assign advance  = ksReady;
    assign issue    = ivValid & advance;
    assign ctrValue = ctrBlockT'(ivIn) + ctrBlockT'(issuePos);

    // IV stays at the FIFO head until the last counter of its bucket
    assign ivReady = issue & (issuePos == chunkIdxT'(`BktChunks - 1));

    always_ff @(posedge Clock or negedge arstN) begin
        if (!arstN) begin
            issuePos <= '0;
        end else if (issue) begin
            if (issuePos == chunkIdxT'(`BktChunks - 1)) issuePos <= '0;
            else issuePos <= issuePos + 1'b1;
        end
    end

    //------------------------------------------------------------------
    // Round pipeline
    //------------------------------------------------------------------

    always_ff @(posedge Clock or negedge arstN) begin
        if (!arstN) begin
            for (int k = 0; k < `Rounds; k++) stageVld[k] <= 1'b0;
        end else if (advance) begin
            stageVld[0] <= issue;
            for (int k = 1; k < `Rounds; k++) stageVld[k] <= stageVld[k-1];
        end
    end

    always_ff @(posedge Clock) begin
        if (advance) begin
            stageData[0] <= mixRound(ctrValue, roundIdxT'(0));
            for (int k = 1; k < `Rounds; k++) begin
                stageData[k] <= mixRound(stageData[k-1], roundIdxT'(k));
            end
        end
    end

    // Last stage is consumed on the same edge the pipe advances
    assign ksOut   = stageData[`Rounds-1];
    assign ksValid = stageVld[`Rounds-1];

endmodule

/* logic/bucketTracker.sv */
//----------------------------------------------------------------------
// Merges the two input ports and tracks the in-bucket position.
// The backend port wins when both are valid in the same cycle.
//----------------------------------------------------------------------
`timescale 1ns/1ns
`include "oram_macros.svh"

module bucketTracker import bucketPkg::*; (
    input  logic  Clock,
    input  logic  arstN,
    input  chunkT backendWData,
    input  logic  backendWValid,
    output logic  backendWReady,
    input  chunkT dramRData,
    input  logic  dramRValid,
    output logic  dramRReady,
    output chunkT dataOut,
    output logic  dataValid,
    input  logic  dataReady,
    output ivT    ivOut,
    output logic  ivValid,
    input  logic  ivReady
);

    chunkT    inData;
    logic     inValid;
    logic     inReady;
    logic     isIvSlot;
    logic     accept;
    chunkIdxT bktPos;

    //------------------------------------------------------------------
    // Input merge
    //------------------------------------------------------------------

    assign inData  = backendWValid ? backendWData : dramRData;
    assign inValid = backendWValid | dramRValid;

    // DRAM side only sees ready when the backend is idle
    assign backendWReady = inReady;
    assign dramRReady    = inReady & ~backendWValid;

    //------------------------------------------------------------------
    // FIFO feed
    //------------------------------------------------------------------

    assign isIvSlot = (bktPos == chunkIdxT'(`IvIndex));

    // IV chunk goes into both FIFOs in one cycle or not at all
    assign inReady   = dataReady & (~isIvSlot | ivReady);
    assign accept    = inValid & inReady;
    assign dataOut   = inData;
    assign dataValid = inValid & (~isIvSlot | ivReady);
    assign ivOut     = ivT'(inData[`IvBits-1:0]);
    assign ivValid   = inValid & isIvSlot & dataReady;

    // Position of the next accepted chunk
    always_ff @(posedge Clock or negedge arstN) begin
        if (!arstN) begin
            bktPos <= '0;
        end else if (accept) begin
            if (bktPos == chunkIdxT'(`BktChunks - 1)) bktPos <= '0;
            else bktPos <= bktPos + 1'b1;
        end
    end

endmodule

/* logic/chunkFifo.sv */
//----------------------------------------------------------------------
// Synchronous FIFO for any payload type. Head is shown combinationally.
// Ready depends only on the fill count.
//----------------------------------------------------------------------
`timescale 1ns/1ns
`include "oram_macros.svh"

module chunkFifo #(
    parameter type payloadT = logic,
    parameter int  Depth    = `FifoDepth
) (
    input  logic    Clock,
    input  logic    arstN,
    input  payloadT inData,
    input  logic    inValid,
    output logic    inReady,
    output payloadT outData,
    output logic    outValid,
    input  logic    outReady
);

    localparam int PtrBits = (Depth > 1) ? $clog2(Depth) : 1;
    localparam int CntBits = $clog2(Depth + 1);

    payloadT            mem [Depth];
    logic [PtrBits-1:0] wrPtr;
    logic [PtrBits-1:0] rdPtr;
    logic [CntBits-1:0] fill;
    logic               push;
    logic               pop;

    // Pointer step with wrap at Depth
    function automatic logic [PtrBits-1:0] nextPtr(input logic [PtrBits-1:0] ptr);
        return (ptr == PtrBits'(Depth - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign inReady  = (fill != CntBits'(Depth));
    assign outValid = (fill != '0);
    assign outData  = mem[rdPtr];
    assign push     = inValid & inReady;
    assign pop      = outValid & outReady;

    always_ff @(posedge Clock) begin
        if (push) begin
            mem[wrPtr] <= inData;
        end
    end

    always_ff @(posedge Clock or negedge arstN) begin
        if (!arstN) begin
            wrPtr <= '0;
            rdPtr <= '0;
            fill  <= '0;
        end else begin
            if (push) wrPtr <= nextPtr(wrPtr);
            if (pop) rdPtr <= nextPtr(rdPtr);
            // Simultaneous push and pop leaves the count alone
            if (push && !pop) fill <= fill + 1'b1;
            else if (pop && !push) fill <= fill - 1'b1;
        end
    end

endmodule

/* logic/cipherPkg.sv */
//----------------------------------------------------------------------
// Keystream and direction types. The round number width assumes
// Rounds is a power of two no larger than four.
//----------------------------------------------------------------------
`include "oram_macros.svh"

package cipherPkg;

    //------------------------------------------------------------------
    // Keystream
    //------------------------------------------------------------------

    // Counter going in, keystream block coming out
    typedef logic [`ChunkBits-1:0] ctrBlockT;

    // Index of a mixing round
    typedef logic [$clog2(`Rounds)-1:0] roundIdxT;

    //------------------------------------------------------------------
    // Direction
    //------------------------------------------------------------------

    // Where the current path goes
    // PathWrite sends to DRAM, PathRead returns to the backend
    typedef enum logic {
        PathWrite = 1'b0,
        PathRead  = 1'b1
    } pathDirT;

endpackage

/* logic/bucketPkg.sv */
//----------------------------------------------------------------------
// Bucket and path layout types. Positions are sized from the macros,
// so BktChunks and PathBuckets are expected to be powers of two.
//----------------------------------------------------------------------
`include "oram_macros.svh"

package bucketPkg;

    //------------------------------------------------------------------
    // Payloads
    //------------------------------------------------------------------

    // One bus beat, also one cipher block
    typedef logic [`ChunkBits-1:0] chunkT;

    // Per-bucket IV, carried in the low bits of the IV chunk
    typedef logic [`IvBits-1:0] ivT;

    //------------------------------------------------------------------
    // Positions
    //------------------------------------------------------------------

    // Chunk position inside a bucket
    typedef logic [$clog2(`BktChunks)-1:0] chunkIdxT;

    // Chunk position inside a path
    typedef logic [$clog2(`BktChunks*`PathBuckets)-1:0] pathIdxT;

endpackage

/* logic/oram_macros.svh */
//----------------------------------------------------------------------
// Geometry, cipher and FIFO constants for the bucket cipher stage.
// FifoDepth must cover at least two buckets so that input keeps flowing.
//----------------------------------------------------------------------
`ifndef ORAM_MACROS_SVH
`define ORAM_MACROS_SVH

// Bus and IV widths
`define ChunkBits 128
`define IvBits 64

// Bucket and path layout
`define BktChunks 8
`define IvIndex 3
`define PathBuckets 4

// Buffering per FIFO
`define FifoDepth 16

// Keyed mixing function standing in for the block cipher
`define Rounds 4
`define CipherKey 128'h3c6ef372_a54ff53a_510e527f_9b05688c
`define RoundConst 128'h9e3779b9_7f4a7c15_f39cc060_5cedc834

`endif
